// ==== hdl/pong_defs.svh ====
`ifndef PONG_DEFS_SVH
`define PONG_DEFS_SVH

// horizontal step and launch state of the ball.
`define PONG_STEP_X 4
`define PONG_START_X 100
`define PONG_START_Y 80
`define PONG_START_VY (-3)

`define PONG_WIDTH_HI 640
`define PONG_WIDTH_LO 320
`define PONG_HEIGHT_HI 480
`define PONG_HEIGHT_LO 240

`define PONG_BALL_SIZE 20 // the right-edge limit is the width minus this.

// paddle left column on the wide screen, 20 pixels before the right-edge limit.
`define PONG_PADDLE_X (`PONG_WIDTH_HI - `PONG_BALL_SIZE - 20)
`define PONG_PADDLE_H 48

`define PONG_BASE_PERIOD 270000
`define PONG_MIN_SPEED 2 // floor applied to the estimated paddle speed.

`endif

// ==== hdl/pong_pkg.sv ====
`default_nettype none

package pong_pkg;

    // ball FSM states, shared with the checker through hierarchy.
    typedef enum logic [1:0] {
        idle          = 2'd0,
        running_right = 2'd1,
        running_left  = 2'd2,
        stop          = 2'd3
    } ball_state_t;

    // pixel coordinate on either screen size.
    typedef logic [9:0] coord_t;

    // vertical velocity in pixels per step, positive is downward.
    typedef logic signed [9:0] vel_t;

    typedef logic [19:0] period_t; // step period in clocks.

endpackage

`default_nettype wire

// ==== hdl/ball_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pong_defs.svh"

module ball_controller #(
    parameter pong_pkg::period_t base_period = `PONG_BASE_PERIOD
) (
    input  logic              clk_25MHZ,
    input  logic              reset,
    input  logic              upscale,
    input  logic              collision,
    input  logic              game_start,
    input  pong_pkg::coord_t  estimated_speed,
    input  logic              div_ack,
    input  pong_pkg::period_t div_quotient,
    output logic              div_req,
    output pong_pkg::coord_t  div_divisor,
    output pong_pkg::coord_t  ball_x,
    output pong_pkg::coord_t  ball_y,
    output pong_pkg::vel_t    ball_vy,
    output logic              moving_left,
    output logic              game_over,
    output logic [7:0]        score,
    output logic              send_pulse
);
    import pong_pkg::*;

    ball_state_t        state, state_next;
    coord_t             ball_x_next, ball_y_next;
    vel_t               ball_vy_next;
    period_t            period, period_next;
    period_t            step_cnt, step_cnt_next;
    logic [1:0]         grav_cnt, grav_cnt_next;
    logic               game_over_next;
    logic               send_pulse_next;
    logic               div_req_next;
    logic               div_load;
    logic [7:0]         score_next;
    coord_t             right_limit, y_max;
    coord_t             step_x, step_y;
    vel_t               vy_grav, step_vy;
    logic signed [11:0] y_sum;
    logic               take_step;

    assign moving_left = (state == running_left);
    assign right_limit = upscale ? coord_t'(`PONG_WIDTH_HI - `PONG_BALL_SIZE)
                                 : coord_t'(`PONG_WIDTH_LO - `PONG_BALL_SIZE);
    assign y_max = upscale ? coord_t'(`PONG_HEIGHT_HI - 1) : coord_t'(`PONG_HEIGHT_LO - 1);

    // one step of ball physics in the current direction.
    always_comb begin
        if (state == running_left) begin
            step_x = (ball_x < coord_t'(`PONG_STEP_X)) ? '0 : ball_x - coord_t'(`PONG_STEP_X);
        end else begin
            step_x = ball_x + coord_t'(`PONG_STEP_X);
        end
        vy_grav = (grav_cnt == 2'd3) ? ball_vy + vel_t'(1) : ball_vy; // gravity.
        y_sum = $signed({2'b00, ball_y}) + $signed({{2{ball_vy[9]}}, ball_vy});
        if (y_sum < 0) begin
            step_y = '0;
            step_vy = -vy_grav;
        end else if (y_sum > $signed({2'b00, y_max})) begin
            step_y = y_max; // clamp to the bottom row.
            step_vy = -vy_grav;
        end else begin
            step_y = coord_t'(y_sum);
            step_vy = vy_grav;
        end
    end

    always_comb begin
        state_next = state;
        ball_x_next = ball_x;
        ball_y_next = ball_y;
        ball_vy_next = ball_vy;
        period_next = period;
        step_cnt_next = step_cnt;
        grav_cnt_next = grav_cnt;
        game_over_next = game_over;
        score_next = score;
        send_pulse_next = 1'b0;
        div_req_next = div_req;
        div_load = 1'b0;
        take_step = 1'b0;

        // the divider answer lands whatever the state.
        if (div_req && div_ack) begin
            period_next = div_quotient;
            div_req_next = 1'b0;
        end

        case (state)
            idle, stop: begin
                if (game_start) begin
                    state_next = running_left;
                    score_next = '0;
                    game_over_next = 1'b0;
                    step_cnt_next = '0;
                    grav_cnt_next = '0;
                    period_next = base_period;
                end
            end

            running_right: begin
                if (collision) begin
                    state_next = running_left;
                    step_cnt_next = '0;
                    if (!div_req && !div_ack) begin
                        div_req_next = 1'b1;
                        div_load = 1'b1;
                    end
                end else if (ball_x >= right_limit) begin
                    state_next = stop; // missed the paddle.
                    game_over_next = 1'b1;
                    send_pulse_next = 1'b1;
                end else begin
                    take_step = 1'b1;
                end
            end

            running_left: begin
                if (ball_x == '0) begin
                    state_next = running_right;
                    score_next = score + 8'd1;
                    period_next = base_period;
                    step_cnt_next = '0;
                end else begin
                    take_step = 1'b1;
                end
            end

            default: state_next = idle;
        endcase

        if (take_step) begin
            if (step_cnt >= period) begin
                ball_x_next = step_x;
                ball_y_next = step_y;
                ball_vy_next = step_vy;
                grav_cnt_next = grav_cnt + 2'd1;
                step_cnt_next = '0;
            end else begin
                step_cnt_next = step_cnt + period_t'(1);
            end
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state <= idle;
            ball_x <= coord_t'(`PONG_START_X);
            ball_y <= coord_t'(`PONG_START_Y);
            ball_vy <= vel_t'(`PONG_START_VY);
            period <= base_period;
            step_cnt <= '0;
            grav_cnt <= '0;
            game_over <= 1'b0;
            score <= '0;
            send_pulse <= 1'b0;
            div_req <= 1'b0;
        end else begin
            state <= state_next;
            ball_x <= ball_x_next;
            ball_y <= ball_y_next;
            ball_vy <= ball_vy_next;
            period <= period_next;
            step_cnt <= step_cnt_next;
            grav_cnt <= grav_cnt_next;
            game_over <= game_over_next;
            score <= score_next;
            send_pulse <= send_pulse_next;
            div_req <= div_req_next;
        end
    end

    // the divisor stays put while div_req is high.
    always_ff @(posedge clk_25MHZ) begin
        if (div_load) begin
            div_divisor <= (estimated_speed < coord_t'(`PONG_MIN_SPEED))
                           ? coord_t'(`PONG_MIN_SPEED) : estimated_speed;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/speed_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

module speed_divider (
    input  logic              clk_25MHZ,
    input  logic              reset,
    input  logic              req,
    input  pong_pkg::period_t dividend,
    input  pong_pkg::coord_t  divisor,
    output logic              ack,
    output pong_pkg::period_t quotient
);
    import pong_pkg::*;

    localparam int unsigned quo_bits = $bits(period_t);

    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done
    } div_state_t;

    div_state_t  state;
    logic [4:0]  bit_cnt;
    coord_t      dvs_q, rem_q;
    period_t     quo_q;
    coord_t      cur_dvs, cur_rem;
    period_t     cur_quo;
    logic [10:0] trial;
    logic        fits;
    logic        iterate;

    // the first bit is resolved on the edge that accepts req.
    assign iterate = (state == div_busy) || (state == div_idle && req);

    always_comb begin
        if (state == div_busy) begin
            cur_rem = rem_q;
            cur_quo = quo_q;
            cur_dvs = dvs_q;
        end else begin
            cur_rem = '0;
            cur_quo = dividend;
            cur_dvs = divisor;
        end
        trial = {cur_rem, cur_quo[quo_bits-1]};
        fits = (trial >= {1'b0, cur_dvs}); // restoring step.
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state <= div_idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                div_idle: begin
                    if (req) begin
                        state <= div_busy;
                        bit_cnt <= 5'd1;
                    end
                end
                div_busy: begin
                    bit_cnt <= bit_cnt + 5'd1;
                    if (bit_cnt == 5'(quo_bits - 1)) state <= div_done;
                end
                div_done: if (!req) state <= div_idle;
                default: state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (iterate) begin
            rem_q <= fits ? coord_t'(trial - {1'b0, cur_dvs}) : coord_t'(trial);
            quo_q <= {cur_quo[quo_bits-2:0], fits};
            dvs_q <= cur_dvs;
        end
    end

    assign ack = (state == div_done);
    assign quotient = quo_q;

endmodule

`default_nettype wire

// ==== hdl/paddle_collision.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pong_defs.svh"

module paddle_collision (
    input  logic             clk_25MHZ,
    input  logic             reset,
    input  logic             upscale,
    input  pong_pkg::coord_t ball_x,
    input  pong_pkg::coord_t ball_y,
    input  pong_pkg::coord_t paddle_y,
    output logic             collision
);
    import pong_pkg::*;

    coord_t      paddle_left, paddle_right;
    logic [10:0] ball_right, ball_bottom, paddle_bottom;
    logic        overlap, overlap_q;

    // the narrow screen pulls the paddle left by the width difference.
    assign paddle_left = upscale ? coord_t'(`PONG_PADDLE_X)
                                 : coord_t'(`PONG_PADDLE_X - (`PONG_WIDTH_HI - `PONG_WIDTH_LO));
    assign paddle_right = upscale ? coord_t'(`PONG_WIDTH_HI - `PONG_BALL_SIZE)
                                  : coord_t'(`PONG_WIDTH_LO - `PONG_BALL_SIZE);

    assign ball_right = {1'b0, ball_x} + 11'(`PONG_BALL_SIZE);
    assign ball_bottom = {1'b0, ball_y} + 11'(`PONG_BALL_SIZE);
    assign paddle_bottom = {1'b0, paddle_y} + 11'(`PONG_PADDLE_H);

    assign overlap = (ball_right > {1'b0, paddle_left}) && (ball_x <= paddle_right) &&
                     (ball_bottom > {1'b0, paddle_y}) && ({1'b0, ball_y} < paddle_bottom);

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            overlap_q <= 1'b0;
            collision <= 1'b0;
        end else begin
            overlap_q <= overlap;
            collision <= overlap && !overlap_q; // rising edge of the contact only.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ball_link_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module ball_link_tx (
    input  logic             clk_25MHZ,
    input  logic             reset,
    input  logic             send_pulse,
    input  pong_pkg::coord_t ball_y,
    input  pong_pkg::vel_t   ball_vy,
    input  logic             link_ack,
    output logic             link_req,
    output pong_pkg::coord_t link_y,
    output pong_pkg::vel_t   link_vy
);

    typedef enum logic [1:0] {
        tx_idle,
        tx_request,
        tx_release
    } tx_state_t;

    tx_state_t state;
    logic      accept;

    // a pulse during a busy transfer is dropped.
    assign accept = (state == tx_idle) && send_pulse;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state <= tx_idle;
            link_req <= 1'b0;
        end else begin
            case (state)
                tx_idle: begin
                    if (send_pulse) begin
                        state <= tx_request;
                        link_req <= 1'b1;
                    end
                end
                tx_request: begin
                    if (link_ack) begin
                        state <= tx_release;
                        link_req <= 1'b0;
                    end
                end
                tx_release: if (!link_ack) state <= tx_idle; // wait for ack to drop.
                default: state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (accept) begin
            link_y <= ball_y;
            link_vy <= ball_vy;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pong_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pong_defs.svh"

module pong_core #(
    parameter pong_pkg::period_t base_period = `PONG_BASE_PERIOD
) (
    input  logic             clk_25MHZ,
    input  logic             reset,
    input  logic             upscale,
    input  logic             game_start,
    input  pong_pkg::coord_t paddle_y,
    input  pong_pkg::coord_t estimated_speed,
    input  logic             link_ack,
    output pong_pkg::coord_t ball_x,
    output pong_pkg::coord_t ball_y,
    output logic             moving_left,
    output logic             game_over,
    output logic [7:0]       score,
    output logic             link_req,
    output pong_pkg::coord_t link_y,
    output pong_pkg::vel_t   link_vy
);
    import pong_pkg::*;

    logic    collision;
    logic    div_req, div_ack;
    coord_t  div_divisor;
    period_t div_quotient;
    vel_t    ball_vy;
    logic    send_pulse;

    ball_controller #(
        .base_period(base_period)
    ) i_ball_controller (
        .clk_25MHZ      (clk_25MHZ),
        .reset          (reset),
        .upscale        (upscale),
        .collision      (collision),
        .game_start     (game_start),
        .estimated_speed(estimated_speed),
        .div_ack        (div_ack),
        .div_quotient   (div_quotient),
        .div_req        (div_req),
        .div_divisor    (div_divisor),
        .ball_x         (ball_x),
        .ball_y         (ball_y),
        .ball_vy        (ball_vy),
        .moving_left    (moving_left),
        .game_over      (game_over),
        .score          (score),
        .send_pulse     (send_pulse)
    );

    speed_divider i_speed_divider (
        .clk_25MHZ(clk_25MHZ),
        .reset    (reset),
        .req      (div_req),
        .dividend (base_period),
        .divisor  (div_divisor),
        .ack      (div_ack),
        .quotient (div_quotient)
    );

    paddle_collision i_paddle_collision (
        .clk_25MHZ(clk_25MHZ),
        .reset    (reset),
        .upscale  (upscale),
        .ball_x   (ball_x),
        .ball_y   (ball_y),
        .paddle_y (paddle_y),
        .collision(collision)
    );

    ball_link_tx i_ball_link_tx (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset),
        .send_pulse(send_pulse),
        .ball_y    (ball_y),
        .ball_vy   (ball_vy),
        .link_ack  (link_ack),
        .link_req  (link_req),
        .link_y    (link_y),
        .link_vy   (link_vy)
    );

endmodule

`default_nettype wire

// ==== test/pong_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pong_defs.svh"

module pong_checker #(
    parameter pong_pkg::period_t base_period = `PONG_BASE_PERIOD
) (
    input  logic                  clk_25MHZ,
    input  logic                  reset,
    input  logic                  upscale,
    input  logic                  game_start,
    input  pong_pkg::coord_t      estimated_speed,
    input  pong_pkg::coord_t      ball_x,
    input  pong_pkg::coord_t      ball_y,
    input  logic                  moving_left,
    input  logic                  game_over,
    input  logic [7:0]            score,
    input  pong_pkg::ball_state_t state,
    input  logic                  link_req,
    input  logic                  link_ack,
    input  pong_pkg::coord_t      link_y,
    input  pong_pkg::vel_t        link_vy
);
    import pong_pkg::*;

    int          errors = 0;
    int          steps_checked = 0;
    int          handoffs_checked = 0;
    coord_t      mdl_x, mdl_y, prev_x, prev_y, prev_link_y;
    vel_t        mdl_vy, prev_link_vy;
    ball_state_t prev_state;
    logic [29:0] nxt;
    int          step_idx, gap, exp_period, exp_score, speed_floor;
    logic        first_gap, exp_go, prev_req, prev_ack;

    // next x, y and vy of the ball after one step, packed as {x, y, vy}.
    function automatic logic [29:0] ball_model(coord_t x, coord_t y, vel_t vy, int idx,
                                               logic left, logic up);
        int nx;
        int ny;
        int nvy;
        int vy_new;
        int bottom;
        nx = left ? int'(x) - `PONG_STEP_X : int'(x) + `PONG_STEP_X;
        if (nx < 0) nx = 0;
        bottom = up ? `PONG_HEIGHT_HI - 1 : `PONG_HEIGHT_LO - 1;
        vy_new = int'(vy) + ((idx % 4 == 3) ? 1 : 0); // gravity on every fourth step.
        ny = int'(y) + int'(vy);
        if (ny < 0) begin
            ny = 0;
            nvy = -vy_new;
        end else if (ny > bottom) begin
            ny = bottom;
            nvy = -vy_new;
        end else begin
            nvy = vy_new;
        end
        return {nx[9:0], ny[9:0], nvy[9:0]};
    endfunction

    function automatic int right_limit(logic up);
        return up ? `PONG_WIDTH_HI - `PONG_BALL_SIZE : `PONG_WIDTH_LO - `PONG_BALL_SIZE;
    endfunction

    task automatic flag_error(string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    always @(negedge clk_25MHZ) begin
        if (reset) begin
            mdl_x = coord_t'(`PONG_START_X);
            mdl_y = coord_t'(`PONG_START_Y);
            mdl_vy = vel_t'(`PONG_START_VY);
            prev_x = mdl_x;
            prev_y = mdl_y;
            prev_state = idle;
            step_idx = 0;
            gap = 0;
            exp_period = int'(base_period);
            exp_score = 0;
            exp_go = 1'b0;
            first_gap = 1'b1;
            prev_req = 1'b0;
            prev_ack = 1'b0;
        end else begin
            gap = gap + 1;
            // direction changes that took effect at the last edge.
            if (prev_state == running_left && state == running_right) begin
                exp_score++;
                exp_period = int'(base_period);
                first_gap = 1'b1;
                if (int'(ball_x) != 0) flag_error("turned right away from the left edge");
            end else if (prev_state == running_right && state == running_left) begin
                speed_floor = int'(estimated_speed);
                if (speed_floor < `PONG_MIN_SPEED) speed_floor = `PONG_MIN_SPEED;
                exp_period = int'(base_period) / speed_floor;
                first_gap = 1'b1;
            end else if (prev_state == running_right && state == stop) begin
                exp_go = 1'b1;
                if (int'(ball_x) != right_limit(upscale)) begin
                    flag_error($sformatf("stopped at x %0d", ball_x));
                end
            end

            if (ball_x != prev_x || ball_y != prev_y) begin
                if (state == idle || state == stop) begin
                    flag_error("ball moved while the game was stopped");
                end else begin
                    nxt = ball_model(mdl_x, mdl_y, mdl_vy, step_idx,
                                     state == running_left, upscale);
                    steps_checked++;
                    if (ball_x != nxt[29:20] || ball_y != nxt[19:10]) begin
                        flag_error($sformatf("step %0d at %0d,%0d, expected %0d,%0d",
                                             step_idx, ball_x, ball_y, nxt[29:20], nxt[19:10]));
                    end
                    if (moving_left != (ball_x < prev_x)) begin
                        flag_error($sformatf("moving_left is %0b while x went from %0d to %0d",
                                             moving_left, prev_x, ball_x));
                    end
                    if (!first_gap && gap != exp_period + 1) begin
                        flag_error($sformatf("step spacing %0d, expected %0d",
                                             gap, exp_period + 1));
                    end
                    mdl_x = ball_x;
                    mdl_y = ball_y;
                    mdl_vy = nxt[9:0];
                    step_idx++;
                    first_gap = 1'b0;
                end
                gap = 0;
            end

            if (score != exp_score[7:0]) begin
                flag_error($sformatf("score %0d, expected %0d", score, exp_score));
            end
            if (game_over != exp_go) flag_error($sformatf("game_over is %0b", game_over));

            // four-phase rules of the outgoing link.
            if (link_req && !prev_req) begin
                handoffs_checked++;
                if (prev_ack) flag_error("link_req rose while link_ack was still high");
                if (link_y != mdl_y || link_vy != mdl_vy) begin
                    flag_error($sformatf("hand-off %0d,%0d, expected %0d,%0d",
                                         link_y, link_vy, mdl_y, mdl_vy));
                end
            end
            if (!link_req && prev_req && !prev_ack) flag_error("link_req fell before link_ack");
            if (link_req && prev_req && (link_y != prev_link_y || link_vy != prev_link_vy)) begin
                flag_error("link data changed during a transfer");
            end

            // a start request is taken at the next edge.
            if (game_start && (state == idle || state == stop)) begin
                step_idx = 0;
                exp_score = 0;
                exp_go = 1'b0;
                exp_period = int'(base_period);
                first_gap = 1'b1;
            end

            prev_x = ball_x;
            prev_y = ball_y;
            prev_state = state;
            prev_req = link_req;
            prev_ack = link_ack;
            prev_link_y = link_y;
            prev_link_vy = link_vy;
        end
    end

endmodule

`default_nettype wire

// ==== test/pong_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pong_core_tb;
    import pong_pkg::*;

    localparam period_t base_period = 40;
    // horizontal steps of all tests, the slowest at base_period + 1 clocks.
    localparam int total_steps = 25 + 4 * (155 + 146) + 155 + 155 + 75 + 71 + 75;
    localparam int cycle_limit = total_steps * (int'(base_period) + 1) * 3 / 2 + 1000;

    logic       clk_25MHZ = 1'b0;
    logic       reset, upscale, game_start, link_ack;
    coord_t     paddle_y = coord_t'(1000);
    coord_t     estimated_speed;
    coord_t     ball_x, ball_y, link_y;
    vel_t       link_vy;
    logic       moving_left, game_over, link_req;
    logic [7:0] score;
    logic       follow_paddle;
    int         tb_errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         handshakes = 0;
    int         seed = 94;
    int         cycles;
    int         snap;
    int         speeds [4] = '{0, 1, 3, 7};

    always #20 clk_25MHZ = ~clk_25MHZ;

    pong_core #(.base_period(base_period)) i_dut (
        .clk_25MHZ(clk_25MHZ), .reset(reset), .upscale(upscale), .game_start(game_start),
        .paddle_y(paddle_y), .estimated_speed(estimated_speed), .link_ack(link_ack),
        .ball_x(ball_x), .ball_y(ball_y), .moving_left(moving_left), .game_over(game_over),
        .score(score), .link_req(link_req), .link_y(link_y), .link_vy(link_vy)
    );

    pong_checker #(.base_period(base_period)) i_chk (
        .clk_25MHZ(clk_25MHZ), .reset(reset), .upscale(upscale), .game_start(game_start),
        .estimated_speed(estimated_speed), .ball_x(ball_x), .ball_y(ball_y),
        .moving_left(moving_left), .game_over(game_over), .score(score),
        .state(i_dut.i_ball_controller.state), .link_req(link_req), .link_ack(link_ack),
        .link_y(link_y), .link_vy(link_vy)
    );

    // the paddle either tracks the ball or parks below the screen.
    always @(posedge clk_25MHZ) begin
        #2;
        paddle_y <= follow_paddle ? ball_y : coord_t'(1000);
    end

    task automatic opponent_delay();
        int n;
        n = $unsigned($random(seed)) % 8;
        repeat (n) @(posedge clk_25MHZ);
    endtask

    initial begin
        link_ack = 1'b0;
        forever begin
            do @(negedge clk_25MHZ); while (!link_req);
            opponent_delay();
            @(posedge clk_25MHZ);
            #2 link_ack = 1'b1;
            do @(negedge clk_25MHZ); while (link_req);
            opponent_delay();
            @(posedge clk_25MHZ);
            #2 link_ack = 1'b0;
            handshakes++;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk_25MHZ);
            cycles++;
        end
        $display("timeout: the run exceeded %0d clock cycles", cycle_limit);
        $display("Something failed");
        $finish;
    end

    task automatic check_value(string what, int got, int exp);
        if (got != exp) begin
            tb_errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wait_left(logic level);
        do @(negedge clk_25MHZ); while (moving_left !== level);
    endtask

    task automatic pulse_start();
        @(posedge clk_25MHZ);
        #2 game_start = 1'b1;
        @(posedge clk_25MHZ);
        #2 game_start = 1'b0;
    endtask

    task automatic close_test(string name);
        int now_errors;
        now_errors = tb_errors + i_chk.errors;
        tests_run++;
        if (now_errors != snap) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, now_errors - snap);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        snap = now_errors;
    endtask

    initial begin
        reset = 1'b1;
        upscale = 1'b1;
        game_start = 1'b0;
        estimated_speed = '0;
        follow_paddle = 1'b0;
        snap = 0;
        repeat (8) @(posedge clk_25MHZ);
        #2 reset = 1'b0;

        repeat (60) @(negedge clk_25MHZ); // longer than one step period.
        check_value("ball_x", int'(ball_x), 100);
        check_value("ball_y", int'(ball_y), 80);
        check_value("game_over", int'(game_over), 0);
        check_value("link_req", int'(link_req), 0);
        check_value("score", int'(score), 0);
        check_value("moving_left", int'(moving_left), 0);
        close_test("reset state");

        pulse_start();
        @(negedge clk_25MHZ);
        check_value("moving_left", int'(moving_left), 1);
        wait_left(1'b0);
        close_test("leftward physics, wide screen");

        check_value("score", int'(score), 1);
        check_value("ball_x", int'(ball_x), 0);
        do @(negedge clk_25MHZ); while (ball_x < coord_t'(8));
        check_value("moving_left", int'(moving_left), 0);
        close_test("left edge");

        for (int i = 0; i < 4; i++) begin
            @(posedge clk_25MHZ);
            #2;
            estimated_speed = coord_t'(speeds[i]);
            follow_paddle = 1'b1;
            wait_left(1'b1); // turned by the paddle.
            wait_left(1'b0);
            check_value("score", int'(score), i + 2);
        end
        close_test("paddle hits");

        @(posedge clk_25MHZ);
        #2 follow_paddle = 1'b0;
        do @(negedge clk_25MHZ); while (!game_over);
        check_value("ball_x", int'(ball_x), 620);
        while (handshakes < 1) @(negedge clk_25MHZ);
        check_value("hand-offs", i_chk.handoffs_checked, 1);
        close_test("miss and hand-off");

        @(posedge clk_25MHZ);
        #2 upscale = 1'b0;
        pulse_start();
        @(negedge clk_25MHZ);
        check_value("score", int'(score), 0);
        check_value("game_over", int'(game_over), 0);
        check_value("moving_left", int'(moving_left), 1);
        wait_left(1'b0);
        @(posedge clk_25MHZ);
        #2;
        estimated_speed = coord_t'(5);
        follow_paddle = 1'b1;
        wait_left(1'b1);
        wait_left(1'b0);
        @(posedge clk_25MHZ);
        #2 follow_paddle = 1'b0;
        do @(negedge clk_25MHZ); while (!game_over);
        check_value("ball_x", int'(ball_x), 300);
        while (handshakes < 2) @(negedge clk_25MHZ);
        check_value("score", int'(score), 2);
        close_test("restart on the narrow screen");

        $display("tests %0d, failed %0d, steps checked %0d, hand-offs %0d, errors %0d",
                 tests_run, tests_failed, i_chk.steps_checked, i_chk.handoffs_checked,
                 tb_errors + i_chk.errors);
        if (tests_failed == 0 && tb_errors + i_chk.errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pong_core.f ====
+incdir+hdl
hdl/pong_pkg.sv
hdl/ball_controller.sv
hdl/speed_divider.sv
hdl/paddle_collision.sv
hdl/ball_link_tx.sv
hdl/pong_core.sv
test/pong_checker.sv
test/pong_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the pong_core testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f pong_core.f --top-module pong_core_tb \
    --Mdir obj_dir -o pong_core_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/pong_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Everything OK" "$log"; then
    exit 0
fi
exit 1
